// File: hdl/nts_pkg.sv
// Shared widths, register map and identity constants of the NTS engine control side
// Internal addresses are 8 bits; bits 11..8 of the external address select a block

package nts_pkg;

  //--------------------------------------------------
  // Widths and basic types
  //--------------------------------------------------
  localparam int API_ADDR_W = 12;
  localparam int INT_ADDR_W = 8;
  localparam int API_DATA_W = 32;
  localparam int COUNTER_W  = 64;

  typedef logic [API_DATA_W-1:0] api_data_t;
  typedef logic [INT_ADDR_W-1:0] api_addr_t;
  typedef logic [COUNTER_W-1:0]  counter_t;

  // Block select, address bits 11..8
  localparam logic [API_ADDR_W-INT_ADDR_W-1:0] BLOCK_ENGINE = 4'h0;
  localparam logic [API_ADDR_W-INT_ADDR_W-1:0] BLOCK_DEBUG  = 4'h4;

  typedef struct packed {
    logic engine_rd;
    logic debug_rd;
  } api_sel_t;

  //--------------------------------------------------
  // Engine identification block
  //--------------------------------------------------
  localparam api_addr_t ADDR_NAME0   = 8'h00;
  localparam api_addr_t ADDR_NAME1   = 8'h01;
  localparam api_addr_t ADDR_VERSION = 8'h02;
  localparam api_addr_t ADDR_CTRL    = 8'h08;

  localparam api_data_t CORE_NAME0 = 32'h4e_54_53_5f; // "NTS_"
  localparam api_data_t CORE_NAME1 = 32'h45_4e_47_4e; // "ENGN"

  //--------------------------------------------------
  // Debug block
  //--------------------------------------------------
  localparam api_data_t DEBUG_NAME = 32'h44_42_55_47; // "DBUG"

  // Counter upper halves; lower half sits at address + 1
  localparam api_addr_t ADDR_DBG_PROCESSED  = 8'h00;
  localparam api_addr_t ADDR_DBG_BAD_COOKIE = 8'h02;
  localparam api_addr_t ADDR_DBG_BAD_AUTH   = 8'h04;
  localparam api_addr_t ADDR_DBG_BAD_KEYID  = 8'h06;
  localparam api_addr_t ADDR_DBG_NAME       = 8'h08;
  localparam api_addr_t ADDR_DBG_SYSTICK    = 8'h09;
  localparam api_addr_t ADDR_DBG_ERR_CRYPTO = 8'h20;
  localparam api_addr_t ADDR_DBG_ERR_TXBUF  = 8'h22;

  localparam api_data_t SYSTICK_RESET = 32'h0000_0001;

  // One-cycle statistics pulses
  typedef struct packed {
    logic processed;
    logic bad_cookie;
    logic bad_auth;
    logic bad_keyid;
    logic err_crypto;
    logic err_txbuf;
  } stat_events_t;

endpackage

// File: hdl/nts_stat_counter.sv
// 64-bit event counter with a snapshot of its lower half
// The snapshot loads at the edge that ends the upper-half read cycle

module nts_stat_counter (
  input  logic              i_clk,
  input  logic              i_areset,

  input  logic              i_event,    // Count pulse
  input  logic              i_snapshot, // Upper half being read

  output nts_pkg::counter_t o_count,
  output logic [31:0]       o_snap_lo
);

  import nts_pkg::*;

  counter_t    cnt;
  logic [31:0] snap_lo;

  //--------------------------------------------------
  // Counter and snapshot registers
  //--------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      cnt     <= '0;
      snap_lo <= '0;
    end
    else
    begin
      if (i_event)
      begin
        cnt <= cnt + COUNTER_W'(1);
      end
      // Old value, so lower half matches the upper half just read
      if (i_snapshot)
      begin
        snap_lo <= cnt[31:0];
      end
    end
  end

  assign o_count   = cnt;
  assign o_snap_lo = snap_lo;

  // Counter moves by at most one per cycle
  a_cnt_step: assert property (
    @(posedge i_clk) disable iff (i_areset)
    (cnt == $past(cnt)) || (cnt == $past(cnt) + COUNTER_W'(1))
  ) else $error("counter jumped from %0d to %0d", $past(cnt), cnt);

endmodule

// File: hdl/nts_engine_regs.sv
// Engine identification registers, read only
// CTRL always reads 1; unused addresses read zero

module nts_engine_regs #(
  parameter nts_pkg::api_data_t CORE_VERSION = 32'h30_2e_30_32 // "0.02"
) (
  input  nts_pkg::api_addr_t i_addr,
  output nts_pkg::api_data_t o_rdata
);

  import nts_pkg::*;

  localparam api_data_t CTRL_VALUE = 32'h0000_0001;

  // Pure address lookup, gated by the decode
  always_comb
  begin
    o_rdata = '0;
    case (i_addr)
      ADDR_NAME0:
      begin
        o_rdata = CORE_NAME0;
      end
      ADDR_NAME1:
      begin
        o_rdata = CORE_NAME1;
      end
      ADDR_VERSION:
      begin
        o_rdata = CORE_VERSION;
      end
      ADDR_CTRL:
      begin
        o_rdata = CTRL_VALUE; // Engine always enabled
      end
      default:
      begin
        o_rdata = '0;
      end
    endcase
  end

endmodule

// File: hdl/nts_api_decode.sv
// Splits the external address into block select and internal address
// Blocks other than engine and debug are not present and read zero
// No handshake: strobes and read data follow the inputs combinationally

module nts_api_decode (
  input  logic                           i_api_cs,
  input  logic                           i_api_we,
  input  logic [nts_pkg::API_ADDR_W-1:0] i_api_address,

  input  nts_pkg::api_data_t             i_engine_rdata,
  input  nts_pkg::api_data_t             i_debug_rdata,

  output nts_pkg::api_sel_t              o_sel,
  output nts_pkg::api_addr_t             o_addr,
  output nts_pkg::api_data_t             o_api_read_data
);

  import nts_pkg::*;

  localparam int BLOCK_W = API_ADDR_W - INT_ADDR_W;

  logic [BLOCK_W-1:0] block;
  logic               rd_access;
  api_sel_t           sel;

  //--------------------------------------------------
  // Block select
  //--------------------------------------------------
  assign block     = i_api_address[API_ADDR_W-1:INT_ADDR_W];
  assign rd_access = i_api_cs && !i_api_we; // Writes never reach a block

  always_comb
  begin
    sel           = '0;
    sel.engine_rd = rd_access && (block == BLOCK_ENGINE);
    sel.debug_rd  = rd_access && (block == BLOCK_DEBUG);
  end

  assign o_sel  = sel;
  assign o_addr = i_api_address[INT_ADDR_W-1:0];

  //--------------------------------------------------
  // Read data merge
  //--------------------------------------------------
  // Only the selected block contributes, so an OR is enough
  always_comb
  begin
    o_api_read_data = '0;
    if (sel.engine_rd)
    begin
      o_api_read_data = o_api_read_data | i_engine_rdata;
    end
    if (sel.debug_rd)
    begin
      o_api_read_data = o_api_read_data | i_debug_rdata;
    end
  end

  // At most one block answers, and never during a write
  a_sel_onehot: assert final (!(sel.engine_rd && sel.debug_rd) && !(i_api_we && |sel))
    else $error("decode selected more than one block or a block during a write");

endmodule

// File: hdl/nts_debug_regs.sv
// Debug block: six statistics counters, systick and name word
// Reading a counter's upper half latches its lower half for the next read
// Read data is a function of the address only; the decode gates it

module nts_debug_regs (
  input  logic                  i_clk,
  input  logic                  i_areset,

  input  logic                  i_rd,   // Debug read strobe
  input  nts_pkg::api_addr_t    i_addr,
  input  nts_pkg::stat_events_t i_events,

  output nts_pkg::api_data_t    o_rdata
);

  import nts_pkg::*;

  localparam int NUM_STATS = $bits(stat_events_t);

  // Upper-half address per counter, index matches event_vec
  localparam api_addr_t CNT_ADDR [NUM_STATS] = '{
    ADDR_DBG_PROCESSED,
    ADDR_DBG_BAD_COOKIE,
    ADDR_DBG_BAD_AUTH,
    ADDR_DBG_BAD_KEYID,
    ADDR_DBG_ERR_CRYPTO,
    ADDR_DBG_ERR_TXBUF
  };

  logic [NUM_STATS-1:0] event_vec;
  logic [NUM_STATS-1:0] snap_req;
  counter_t             count   [NUM_STATS];
  logic [31:0]          snap_lo [NUM_STATS];
  api_data_t            systick;

  // Bit 0 is processed, same order as CNT_ADDR
  assign event_vec = {i_events.err_txbuf, i_events.err_crypto, i_events.bad_keyid,
                      i_events.bad_auth, i_events.bad_cookie, i_events.processed};

  //--------------------------------------------------
  // Counter bank
  //--------------------------------------------------
  for (genvar i = 0; i < NUM_STATS; i++)
  begin : g_cnt
    assign snap_req[i] = i_rd && (i_addr == CNT_ADDR[i]);

    nts_stat_counter u_cnt (
      .i_clk      (i_clk),
      .i_areset   (i_areset),
      .i_event    (event_vec[i]),
      .i_snapshot (snap_req[i]),
      .o_count    (count[i]),
      .o_snap_lo  (snap_lo[i])
    );
  end

  //--------------------------------------------------
  // Systick
  //--------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      systick <= SYSTICK_RESET;
    end
    else
    begin
      systick <= systick + 32'd1; // Free running, wraps
    end
  end

  //--------------------------------------------------
  // Read mux
  //--------------------------------------------------
  always_comb
  begin
    o_rdata = '0;
    case (i_addr)
      ADDR_DBG_NAME:    o_rdata = DEBUG_NAME;
      ADDR_DBG_SYSTICK: o_rdata = systick;
      default:          o_rdata = '0;
    endcase
    for (int i = 0; i < NUM_STATS; i++)
    begin
      if (i_addr == CNT_ADDR[i])
      begin
        o_rdata = count[i][COUNTER_W-1:32]; // Upper half, live
      end
      else if (i_addr == CNT_ADDR[i] + 8'd1)
      begin
        o_rdata = snap_lo[i]; // Lower half from snapshot
      end
    end
  end

  // Counter addresses are distinct, so one snapshot per read
  a_snap_onehot: assert property (
    @(posedge i_clk) disable iff (i_areset) $onehot0(snap_req)
  ) else $error("more than one snapshot pulse: %b", snap_req);

endmodule

// File: hdl/nts_engine_top.sv
// Control side of the NTS engine: register API, identification and debug counters
// The API is a combinational chip-select read; writes are accepted but read zero
// Statistics events are single-cycle pulses sampled on the rising clock edge

module nts_engine_top #(
  parameter nts_pkg::api_data_t CORE_VERSION = 32'h30_2e_30_32 // "0.02"
) (
  input  logic                           i_clk,
  input  logic                           i_areset,

  input  logic                           i_api_cs,
  input  logic                           i_api_we,
  input  logic [nts_pkg::API_ADDR_W-1:0] i_api_address,
  output nts_pkg::api_data_t             o_api_read_data,

  input  nts_pkg::stat_events_t          i_stat_events
);

  import nts_pkg::*;

  //--------------------------------------------------
  // Internal API wires
  //--------------------------------------------------
  api_sel_t  api_sel;
  api_addr_t api_addr;
  api_data_t engine_rdata;
  api_data_t debug_rdata;

  //--------------------------------------------------
  // Address decode and read merge
  //--------------------------------------------------
  nts_api_decode u_decode (
    .i_api_cs        (i_api_cs),
    .i_api_we        (i_api_we),
    .i_api_address   (i_api_address),
    .i_engine_rdata  (engine_rdata),
    .i_debug_rdata   (debug_rdata),
    .o_sel           (api_sel),
    .o_addr          (api_addr),
    .o_api_read_data (o_api_read_data)
  );

  nts_engine_regs #(
    .CORE_VERSION (CORE_VERSION)
  ) u_engine (
    .i_addr  (api_addr),
    .o_rdata (engine_rdata)
  );

  nts_debug_regs u_debug (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .i_rd     (api_sel.debug_rd), // Latches lower halves
    .i_addr   (api_addr),
    .i_events (i_stat_events),
    .o_rdata  (debug_rdata)
  );

endmodule

// File: verif/tb_nts_debug_tests.svh
// Directed tests and API helpers, included in the testbench module body
// Expected counter values are kept in exp_count; counters start at zero after reset

`ifndef TB_NTS_DEBUG_TESTS_SVH
`define TB_NTS_DEBUG_TESTS_SVH

//--------------------------------------------------
// Helpers
//--------------------------------------------------
function automatic int random_count();
  return (($random(seed) & 32'h7fff_ffff) % 40) + 1; // 1 to 40
endfunction

// Upper-half address of each counter in the debug block (0x4xx)
function automatic logic [11:0] counter_addr(input int idx);
  case (idx)
    0:       return 12'h400;
    1:       return 12'h402;
    2:       return 12'h404;
    3:       return 12'h406;
    4:       return 12'h420;
    default: return 12'h422;
  endcase
endfunction

function automatic stat_events_t event_for(input int idx);
  stat_events_t ev;
  ev = '0;
  case (idx)
    0:       ev.processed  = 1'b1;
    1:       ev.bad_cookie = 1'b1;
    2:       ev.bad_auth   = 1'b1;
    3:       ev.bad_keyid  = 1'b1;
    4:       ev.err_crypto = 1'b1;
    default: ev.err_txbuf  = 1'b1;
  endcase
  return ev;
endfunction

task automatic check_value(input string what, input api_data_t got, input api_data_t exp);
  check_count++;
  assert (got === exp)
  else
  begin
    error_count++;
    $display("mismatch at %0d ns: %s read %h, expected %h", $time, what, got, exp);
  end
endtask

// One access cycle, then the bus goes idle at the next falling edge
task automatic api_access(input logic [11:0] addr, input logic we, output api_data_t data);
  @(negedge clk);
  api_cs      = 1'b1;
  api_we      = we;
  api_address = addr;
  #(CLK_PERIOD / 2 - 1);
  data = api_read_data;
  @(negedge clk);
  api_cs      = 1'b0;
  api_we      = 1'b0;
  api_address = '0;
endtask

task automatic pulse_events(input stat_events_t ev, input int n);
  repeat (n)
  begin
    @(negedge clk);
    stat_events = ev;
  end
  @(negedge clk);
  stat_events = '0;
endtask

// Upper read latches the lower half, lower read follows it
task automatic check_counter(input int idx, input string what);
  api_data_t rd;
  api_access(counter_addr(idx), 1'b0, rd);
  check_value({what, " upper"}, rd, exp_count[idx][63:32]);
  api_access(counter_addr(idx) + 12'd1, 1'b0, rd);
  check_value({what, " lower"}, rd, exp_count[idx][31:0]);
endtask

task automatic report_test(input string name, input int errors_before);
  tests_run++;
  if (error_count == errors_before)
  begin
    $display("%-14s ok", name);
  end
  else
  begin
    $display("%-14s FAILED with %0d errors", name, error_count - errors_before);
  end
endtask

//--------------------------------------------------
// Tests
//--------------------------------------------------
task automatic test_identity();
  int        errors_before;
  api_data_t rd;
  errors_before = error_count;
  api_access(12'h000, 1'b0, rd);
  check_value("engine name0", rd, "NTS_");
  api_access(12'h001, 1'b0, rd);
  check_value("engine name1", rd, "ENGN");
  api_access(12'h002, 1'b0, rd);
  check_value("engine version", rd, "0.02");
  api_access(12'h008, 1'b0, rd);
  check_value("engine ctrl", rd, 32'd1);
  api_access(12'h408, 1'b0, rd);
  check_value("debug name", rd, "DBUG");
  api_access(12'h100, 1'b0, rd); // Dropped blocks
  check_value("block 1", rd, 32'd0);
  api_access(12'h300, 1'b0, rd);
  check_value("block 3", rd, 32'd0);
  api_access(12'h003, 1'b0, rd);
  check_value("engine addr 0x03", rd, 32'd0);
  api_access(12'h40a, 1'b0, rd);
  check_value("debug addr 0x0a", rd, 32'd0);
  report_test("identity", errors_before);
endtask

task automatic test_counting();
  int errors_before;
  int n;
  errors_before = error_count;
  for (int idx = 0; idx < NUM_STATS; idx++)
  begin
    n = random_count();
    pulse_events(event_for(idx), n);
    exp_count[idx] += n;
    check_counter(idx, $sformatf("counter %0d", idx));
  end
  report_test("counting", errors_before);
endtask

task automatic test_snapshot();
  int        errors_before;
  int        n;
  api_data_t rd;
  counter_t  old_count;
  errors_before = error_count;
  old_count = exp_count[1];
  api_access(counter_addr(1), 1'b0, rd);
  check_value("bad cookie upper", rd, old_count[63:32]);
  n = random_count();
  pulse_events(event_for(1), n);
  exp_count[1] += n;
  // No new upper read yet, so the lower half is still the old one
  api_access(counter_addr(1) + 12'd1, 1'b0, rd);
  check_value("bad cookie held lower", rd, old_count[31:0]);
  check_counter(1, "bad cookie new");
  report_test("snapshot", errors_before);
endtask

task automatic test_simultaneous();
  int errors_before;
  int n;
  errors_before = error_count;
  n = random_count();
  pulse_events('1, n);
  for (int idx = 0; idx < NUM_STATS; idx++)
  begin
    exp_count[idx] += n;
    check_counter(idx, $sformatf("all events, counter %0d", idx));
  end
  report_test("simultaneous", errors_before);
endtask

task automatic test_systick_write();
  int        errors_before;
  int        k;
  int        n;
  api_data_t tick0;
  api_data_t tick1;
  api_data_t rd;
  counter_t  old_count;
  errors_before = error_count;

  // Hold a systick read open for k rising edges
  k = random_count();
  @(negedge clk);
  api_cs      = 1'b1;
  api_we      = 1'b0;
  api_address = 12'h409;
  #(CLK_PERIOD / 2 - 1);
  tick0 = api_read_data;
  repeat (k) @(negedge clk);
  #(CLK_PERIOD / 2 - 1);
  tick1 = api_read_data;
  @(negedge clk);
  api_cs      = 1'b0;
  api_address = '0;
  check_value("systick delta", tick1 - tick0, k);

  // A write to an upper half must neither read back nor latch
  old_count = exp_count[0];
  api_access(counter_addr(0), 1'b0, rd);
  check_value("processed upper", rd, old_count[63:32]);
  n = random_count();
  pulse_events(event_for(0), n);
  exp_count[0] += n;
  api_access(counter_addr(0), 1'b1, rd);
  check_value("write access", rd, 32'd0);
  api_access(12'h408, 1'b1, rd); // Name word is nonzero on a read
  check_value("write to debug name", rd, 32'd0);
  api_access(counter_addr(0) + 12'd1, 1'b0, rd);
  check_value("processed lower after write", rd, old_count[31:0]);
  check_counter(0, "processed new");
  report_test("systick/write", errors_before);
endtask

`endif

// File: verif/tb_nts_debug.sv
// Directed testbench for the NTS engine control side, default CORE_VERSION only
// Inputs change on the falling edge; read data is sampled 1 ns before the rising edge

module tb_nts_debug;

  timeunit 1ns;
  timeprecision 100ps;

  import nts_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_STATS   = 6;
  // Longest run is about 700 cycles (six counts of up to 40, reads, snapshot
  // and systick waits); the limit leaves plenty of margin
  localparam int TIMEOUT_CYCLES = 3000;

  //--------------------------------------------------
  // DUT signals
  //--------------------------------------------------
  logic                  clk;
  logic                  areset;
  logic                  api_cs;
  logic                  api_we;
  logic [API_ADDR_W-1:0] api_address;
  api_data_t             api_read_data;
  stat_events_t          stat_events;

  // Scoreboard state
  int       seed = 86;
  int       error_count;
  int       check_count;
  int       tests_run;
  int       cycle_count;
  counter_t exp_count [NUM_STATS];

  nts_engine_top UUT (
    .i_clk           (clk),
    .i_areset        (areset),
    .i_api_cs        (api_cs),
    .i_api_we        (api_we),
    .i_api_address   (api_address),
    .o_api_read_data (api_read_data),
    .i_stat_events   (stat_events)
  );

  `include "tb_nts_debug_tests.svh"

  //--------------------------------------------------
  // Clock and timeout
  //--------------------------------------------------
  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  //--------------------------------------------------
  // Main sequence
  //--------------------------------------------------
  initial
  begin
    areset      = 1'b1;
    api_cs      = 1'b0;
    api_we      = 1'b0;
    api_address = '0;
    stat_events = '0;
    error_count = 0;
    check_count = 0;
    tests_run   = 0;
    for (int i = 0; i < NUM_STATS; i++)
    begin
      exp_count[i] = '0;
    end

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    areset = 1'b0;

    test_identity();
    test_counting();
    test_snapshot();
    test_simultaneous();
    test_systick_write();

    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, check_count,
             error_count);
    if (error_count == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: nts_debug.f
+incdir+verif
hdl/nts_pkg.sv
hdl/nts_stat_counter.sv
hdl/nts_engine_regs.sv
hdl/nts_api_decode.sv
hdl/nts_debug_regs.sv
hdl/nts_engine_top.sv
verif/tb_nts_debug.sv
